/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_ahb_master
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert

SOURCES := $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

/* design/ahb_addr_phase.sv */
// ************************************************
// Address phase stage of the AHB-Lite master.
// Issues SINGLE, INCR4/8/16 and WRAP4/8/16 bursts.
// No BUSY transfers are generated.
// abort returns htrans to IDLE on the next edge.
// ************************************************

module ahb_addr_phase #(
    parameter int ADDR_WIDTH = 32
) (
    input  logic                    ahb_clk_in,
    input  logic                    ahb_rstn_in,
    input  logic                    chk_valid,
    input  logic [ADDR_WIDTH-1:0]   chk_addr,
    input  logic [2:0]              chk_burst,
    input  logic [2:0]              chk_size,
    input  logic                    chk_write,
    input  logic                    hready,
    input  logic                    abort,
    output logic                    addr_ready,
    output logic [ADDR_WIDTH-1:0]   haddr,
    output logic [2:0]              hburst,
    output logic [2:0]              hsize,
    output ahb_master_pkg::htrans_e htrans,
    output logic                    hwrite,
    output logic                    beat_valid,
    output logic                    beat_write,
    output logic                    beat_last,
    output logic                    wdata_take
);
    import ahb_master_pkg::*;

    burst_code_u           new_burst;
    burst_code_u           cur_burst;
    logic [4:0]            beats_left;
    logic                  active;
    logic                  start;
    logic [ADDR_WIDTH-1:0] step;
    logic [ADDR_WIDTH-1:0] wrap_mask;
    logic [ADDR_WIDTH-1:0] incr_addr;
    logic [ADDR_WIDTH-1:0] next_addr;

    assign new_burst = chk_burst;
    assign hburst    = cur_burst.raw;

    // The FSM state is the transfer type itself: IDLE, NONSEQ or SEQ.
    assign active     = htrans != IDLE;
    assign addr_ready = !active;
    assign start      = chk_valid && addr_ready;

    // A beat counts once its address phase sees hready high.
    assign beat_valid = active && hready;
    assign beat_write = hwrite;
    assign beat_last  = beats_left == '0;
    assign wdata_take = beat_valid && hwrite;

    // Wrap bursts keep the upper address bits and wrap the lower ones
    // inside a window of beats times transfer size.
    assign step      = ADDR_WIDTH'(size_bytes(hsize));
    assign wrap_mask = (ADDR_WIDTH'(burst_beats(cur_burst.f.len)) << hsize) - 1'b1;
    assign incr_addr = haddr + step;

    always_comb begin
        if (cur_burst.f.incr) begin
            next_addr = incr_addr;
        end else begin
            next_addr = (haddr & ~wrap_mask) | (incr_addr & wrap_mask);
        end
    end

    always_ff @(posedge ahb_clk_in or negedge ahb_rstn_in) begin
        if (!ahb_rstn_in) begin
            htrans     <= IDLE;
            beats_left <= '0;
            haddr      <= '0;
            cur_burst  <= '0;
            hsize      <= '0;
            hwrite     <= 1'b0;
        end else if (start) begin
            htrans     <= NONSEQ;
            haddr      <= chk_addr;
            cur_burst  <= new_burst;
            hsize      <= chk_size;
            hwrite     <= chk_write;
            beats_left <= burst_beats(new_burst.f.len) - 1'b1;
        end else if (active) begin
            if (abort) begin
                htrans <= IDLE;
            end else if (hready) begin
                if (beat_last) begin
                    htrans <= IDLE;
                end else begin
                    htrans     <= SEQ;
                    haddr      <= next_addr;
                    beats_left <= beats_left - 1'b1;
                end
            end
        end
    end

endmodule

/* design/ahb_data_phase.sv */
// ************************************************
// Data phase stage of the AHB-Lite master.
// Expects the two-cycle ERROR response of AHB-Lite.
// A rejection must not coincide with a completion.
// WAIT_TIMEOUT must be at least 1.
// ************************************************

module ahb_data_phase #(
    parameter int DATA_WIDTH   = 32,
    parameter int WAIT_TIMEOUT = 6
) (
    input  logic                  ahb_clk_in,
    input  logic                  ahb_rstn_in,
    input  logic                  beat_valid,
    input  logic                  beat_write,
    input  logic                  beat_last,
    input  logic                  rej_pulse,
    input  logic [DATA_WIDTH-1:0] wdata,
    input  logic [DATA_WIDTH-1:0] hrdata,
    input  logic                  hready,
    input  logic                  hresp,
    output logic [DATA_WIDTH-1:0] hwdata,
    output logic                  abort,
    output logic                  rsp_valid,
    output logic [DATA_WIDTH-1:0] rsp_rdata,
    output logic                  rsp_error
);
    localparam int CNT_WIDTH = $clog2(WAIT_TIMEOUT + 1);

    logic                 dp_valid;
    logic                 dp_write;
    logic                 dp_last;
    logic [CNT_WIDTH-1:0] wait_cnt;
    logic                 timed_out;
    logic                 done;
    logic                 dp_error;

    // The timeout fires on the WAIT_TIMEOUT-th consecutive low hready.
    assign timed_out = dp_valid && !hready && (wait_cnt == CNT_WIDTH'(WAIT_TIMEOUT - 1));
    assign done      = dp_valid && (hready || timed_out);
    assign dp_error  = hresp || timed_out;

    // Stop the rest of the burst in the first cycle of an ERROR response.
    // On the last beat there is nothing left to stop, and the address
    // stage may already be starting the next burst.
    assign abort = dp_valid && !dp_last && ((hresp && !hready) || timed_out);

    always_ff @(posedge ahb_clk_in or negedge ahb_rstn_in) begin
        if (!ahb_rstn_in) begin
            dp_valid  <= 1'b0;
            dp_write  <= 1'b0;
            dp_last   <= 1'b0;
            wait_cnt  <= '0;
            rsp_valid <= 1'b0;
            rsp_error <= 1'b0;
        end else begin
            if (beat_valid) begin
                dp_valid <= 1'b1;
                dp_write <= beat_write;
                dp_last  <= beat_last;
            end else if (done) begin
                dp_valid <= 1'b0;
            end

            if (!dp_valid || hready || timed_out) begin
                wait_cnt <= '0;
            end else begin
                wait_cnt <= wait_cnt + 1'b1;
            end

            rsp_valid <= done || rej_pulse;
            rsp_error <= (done && dp_error) || rej_pulse;
        end
    end

    // Write data is taken with the address phase and held through wait states.
    always_ff @(posedge ahb_clk_in) begin
        if (beat_valid && beat_write) begin
            hwdata <= wdata;
        end
        if (done || rej_pulse) begin
            rsp_rdata <= (done && !dp_write && !dp_error) ? hrdata : '0;
        end
    end

endmodule

/* design/ahb_master_pkg.sv */
// ************************************************
// Shared AHB-Lite encodings for the bus master.
// The undefined-length INCR burst is not supported.
// Length code 0 always means a single transfer.
// ************************************************

package ahb_master_pkg;

    typedef enum logic [1:0] {
        IDLE   = 2'b00,
        BUSY   = 2'b01,
        NONSEQ = 2'b10,
        SEQ    = 2'b11
    } htrans_e;

    // HBURST split into a length code and the incrementing flag.
    // Wrap bursts have the flag clear.
    typedef struct packed {
        logic [1:0] len;
        logic       incr;
    } burst_fields_t;

    typedef union packed {
        logic [2:0]    raw;
        burst_fields_t f;
    } burst_code_u;

    // No burst may cross this address boundary.
    localparam int BOUNDARY_BYTES = 1024;

    function automatic logic [4:0] burst_beats(input logic [1:0] len);
        logic [4:0] beats;
        case (len)
            2'd1:    beats = 5'd4;
            2'd2:    beats = 5'd8;
            2'd3:    beats = 5'd16;
            default: beats = 5'd1;
        endcase
        return beats;
    endfunction

    function automatic logic [7:0] size_bytes(input logic [2:0] size);
        return 8'd1 << size;
    endfunction

endpackage

/* design/ahb_master_top.sv */
// ************************************************
// AHB-Lite bus master, three-stage pipeline.
// Client fields are held for the whole burst.
// No HPROT, no write strobes, no INCR bursts.
// ************************************************

module ahb_master_top #(
    parameter int ADDR_WIDTH   = 32,
    parameter int DATA_WIDTH   = 32,
    parameter int WAIT_TIMEOUT = 6
) (
    input  logic                    ahb_clk_in,
    input  logic                    ahb_rstn_in,
    input  logic                    req_valid,
    input  logic [ADDR_WIDTH-1:0]   req_addr,
    input  logic [2:0]              req_burst,
    input  logic [2:0]              req_size,
    input  logic                    req_write,
    input  logic [DATA_WIDTH-1:0]   wdata,
    output logic                    req_accept,
    output logic                    wdata_take,
    output logic                    rsp_valid,
    output logic [DATA_WIDTH-1:0]   rsp_rdata,
    output logic                    rsp_error,
    output logic [ADDR_WIDTH-1:0]   haddr,
    output logic [2:0]              hburst,
    output logic [2:0]              hsize,
    output ahb_master_pkg::htrans_e htrans,
    output logic                    hwrite,
    output logic [DATA_WIDTH-1:0]   hwdata,
    input  logic [DATA_WIDTH-1:0]   hrdata,
    input  logic                    hready,
    input  logic                    hresp
);
    logic                  chk_valid;
    logic [ADDR_WIDTH-1:0] chk_addr;
    logic [2:0]            chk_burst;
    logic [2:0]            chk_size;
    logic                  chk_write;
    logic                  rej_pulse;
    logic                  addr_ready;
    logic                  beat_valid;
    logic                  beat_write;
    logic                  beat_last;
    logic                  abort;

    ahb_req_check #(
        .ADDR_WIDTH (ADDR_WIDTH),
        .DATA_WIDTH (DATA_WIDTH)
    ) req_check_i (
        .ahb_clk_in  (ahb_clk_in),
        .ahb_rstn_in (ahb_rstn_in),
        .req_valid   (req_valid),
        .req_addr    (req_addr),
        .req_burst   (req_burst),
        .req_size    (req_size),
        .req_write   (req_write),
        .addr_ready  (addr_ready),
        .req_accept  (req_accept),
        .chk_valid   (chk_valid),
        .chk_addr    (chk_addr),
        .chk_burst   (chk_burst),
        .chk_size    (chk_size),
        .chk_write   (chk_write),
        .rej_pulse   (rej_pulse)
    );

    ahb_addr_phase #(
        .ADDR_WIDTH (ADDR_WIDTH)
    ) addr_phase_i (
        .ahb_clk_in  (ahb_clk_in),
        .ahb_rstn_in (ahb_rstn_in),
        .chk_valid   (chk_valid),
        .chk_addr    (chk_addr),
        .chk_burst   (chk_burst),
        .chk_size    (chk_size),
        .chk_write   (chk_write),
        .hready      (hready),
        .abort       (abort),
        .addr_ready  (addr_ready),
        .haddr       (haddr),
        .hburst      (hburst),
        .hsize       (hsize),
        .htrans      (htrans),
        .hwrite      (hwrite),
        .beat_valid  (beat_valid),
        .beat_write  (beat_write),
        .beat_last   (beat_last),
        .wdata_take  (wdata_take)
    );

    ahb_data_phase #(
        .DATA_WIDTH   (DATA_WIDTH),
        .WAIT_TIMEOUT (WAIT_TIMEOUT)
    ) data_phase_i (
        .ahb_clk_in  (ahb_clk_in),
        .ahb_rstn_in (ahb_rstn_in),
        .beat_valid  (beat_valid),
        .beat_write  (beat_write),
        .beat_last   (beat_last),
        .rej_pulse   (rej_pulse),
        .wdata       (wdata),
        .hrdata      (hrdata),
        .hready      (hready),
        .hresp       (hresp),
        .hwdata      (hwdata),
        .abort       (abort),
        .rsp_valid   (rsp_valid),
        .rsp_rdata   (rsp_rdata),
        .rsp_error   (rsp_error)
    );

endmodule

/* design/ahb_req_check.sv */
// ************************************************
// Request check stage of the AHB-Lite master.
// The boundary check uses the linear end address,
// so it is conservative for wrap bursts.
// The client holds its fields for the whole burst.
// ************************************************

module ahb_req_check #(
    parameter int ADDR_WIDTH = 32,
    parameter int DATA_WIDTH = 32
) (
    input  logic                  ahb_clk_in,
    input  logic                  ahb_rstn_in,
    input  logic                  req_valid,
    input  logic [ADDR_WIDTH-1:0] req_addr,
    input  logic [2:0]            req_burst,
    input  logic [2:0]            req_size,
    input  logic                  req_write,
    input  logic                  addr_ready,
    output logic                  req_accept,
    output logic                  chk_valid,
    output logic [ADDR_WIDTH-1:0] chk_addr,
    output logic [2:0]            chk_burst,
    output logic [2:0]            chk_size,
    output logic                  chk_write,
    output logic                  rej_pulse
);
    import ahb_master_pkg::*;

    localparam int BOUND_BITS = $clog2(BOUNDARY_BYTES);

    logic                  busy;
    burst_code_u           burst_u;
    logic [ADDR_WIDTH-1:0] size_mask;
    logic [ADDR_WIDTH-1:0] burst_span;
    logic [ADDR_WIDTH-1:0] end_addr;
    logic                  aligned;
    logic                  size_ok;
    logic                  in_bound;
    logic                  legal;

    assign req_accept = req_valid && !busy;

    assign burst_u    = chk_burst;
    assign size_mask  = ADDR_WIDTH'(size_bytes(chk_size)) - 1'b1;
    assign burst_span = ADDR_WIDTH'(burst_beats(burst_u.f.len)) << chk_size;
    assign end_addr   = chk_addr + burst_span - 1'b1;

    assign aligned  = (chk_addr & size_mask) == '0;
    assign size_ok  = int'(size_bytes(chk_size)) * 8 <= DATA_WIDTH;
    assign in_bound = (end_addr >> BOUND_BITS) == (chk_addr >> BOUND_BITS);
    assign legal    = aligned && size_ok && in_bound;

    // The check takes one cycle after the request is registered.
    // A legal request then waits in chk_valid for the address stage.
    always_ff @(posedge ahb_clk_in or negedge ahb_rstn_in) begin
        if (!ahb_rstn_in) begin
            busy      <= 1'b0;
            chk_valid <= 1'b0;
            rej_pulse <= 1'b0;
        end else begin
            rej_pulse <= 1'b0;
            if (req_accept) begin
                busy <= 1'b1;
            end else if (busy && !chk_valid) begin
                chk_valid <= legal;
                rej_pulse <= !legal;
                busy      <= legal;
            end else if (chk_valid && addr_ready) begin
                chk_valid <= 1'b0;
                busy      <= 1'b0;
            end
        end
    end

    always_ff @(posedge ahb_clk_in) begin
        if (req_accept) begin
            chk_addr  <= req_addr;
            chk_burst <= req_burst;
            chk_size  <= req_size;
            chk_write <= req_write;
        end
    end

endmodule

/* tb.f */
design/ahb_master_pkg.sv
design/ahb_req_check.sv
design/ahb_addr_phase.sv
design/ahb_data_phase.sv
design/ahb_master_top.sv
tb/ahb_slave_model.sv
tb/tb_ahb_master.sv

/* tb/ahb_slave_model.sv */
// ************************************************
// AHB-Lite slave with a 4 KB word memory.
// Writes store the full word whatever HSIZE says.
// Errors use the two-cycle ERROR response.
// ************************************************

module ahb_slave_model (
    input  logic        ahb_clk_in,
    input  logic        ahb_rstn_in,
    input  logic [31:0] haddr,
    input  logic [1:0]  htrans,
    input  logic        hwrite,
    input  logic [31:0] hwdata,
    input  int          max_wait,
    input  logic        stall,
    input  int          err_beat,
    output logic [31:0] hrdata,
    output logic        hready,
    output logic        hresp
);
    timeunit 1ns;
    timeprecision 100ps;

    logic [31:0] mem [0:1023];
    logic        pend;
    logic        pend_write;
    logic [9:0]  pend_idx;
    int          wait_left;
    logic [1:0]  err_ph;
    int          beat_cnt;

    initial begin
        for (int i = 0; i < 1024; i++) begin
            mem[i] = 32'h5a00_0000 ^ (32'(i) * 32'h0001_0193);
        end
    end

    // err_ph 1 is the first ERROR cycle, 2 the second.
    always_comb begin
        hready = 1'b1;
        hresp  = 1'b0;
        if (pend) begin
            if (stall || wait_left > 0) begin
                hready = 1'b0;
            end else if (err_ph == 2'd1) begin
                hready = 1'b0;
                hresp  = 1'b1;
            end else if (err_ph == 2'd2) begin
                hresp = 1'b1;
            end
        end
    end

    assign hrdata = (pend && !pend_write && hready) ? mem[pend_idx] : '0;

    always @(posedge ahb_clk_in or negedge ahb_rstn_in) begin
        if (!ahb_rstn_in) begin
            pend      <= 1'b0;
            wait_left <= 0;
            err_ph    <= 2'd0;
            beat_cnt  <= 0;
        end else begin
            if (pend && !stall) begin
                if (wait_left > 0) begin
                    wait_left <= wait_left - 1;
                end else if (err_ph == 2'd1) begin
                    err_ph <= 2'd2;
                end else begin
                    if (pend_write && err_ph == 2'd0) begin
                        mem[pend_idx] <= hwdata;
                    end
                    pend <= 1'b0;
                end
            end
            if (hready && htrans[1]) begin
                pend       <= 1'b1;
                pend_write <= hwrite;
                pend_idx   <= haddr[11:2];
                wait_left  <= (max_wait > 0) ? int'($urandom_range(32'(max_wait), 0)) : 0;
                err_ph     <= (beat_cnt == err_beat) ? 2'd1 : 2'd0;
                beat_cnt   <= beat_cnt + 1;
            end
        end
    end

endmodule

/* tb/tb_ahb_master.sv */
// ************************************************
// Testbench for the AHB-Lite master.
// Random bursts stay inside 4 KB and never cross
// a 1 KB boundary. Read data is compared for word
// transfers only.
// ************************************************

module tb_ahb_master;
    timeunit 1ns;
    timeprecision 100ps;
    import ahb_master_pkg::*;

    localparam int WAIT_TIMEOUT = 6;
    localparam int NREQ = 41;
    localparam int LIMIT = NREQ * 16 * (WAIT_TIMEOUT + 2) + 200;

    logic        clk;
    logic        rstn;
    logic        req_valid;
    logic [31:0] req_addr;
    logic [2:0]  req_burst;
    logic [2:0]  req_size;
    logic        req_write;
    logic [31:0] wdata;
    logic        req_accept;
    logic        wdata_take;
    logic        rsp_valid;
    logic [31:0] rsp_rdata;
    logic        rsp_error;
    logic [31:0] haddr;
    logic [2:0]  hburst;
    logic [2:0]  hsize;
    htrans_e     htrans;
    logic        hwrite;
    logic [31:0] hwdata;
    logic [31:0] hrdata;
    logic        hready;
    logic        hresp;
    int          max_wait;
    logic        stall;
    int          err_beat;
    int          cycles;
    logic        rej_mode;
    logic [31:0] exp_q[$];
    bit          first_q[$];
    logic [31:0] wq[$];
    logic [31:0] saved[$];
    logic [31:0] rd_q[$];
    int          rsp_cnt;
    logic        got_err;
    logic [2:0]  exp_burst;
    logic [2:0]  exp_size;
    logic        exp_write;

    ahb_master_top #(
        .WAIT_TIMEOUT (WAIT_TIMEOUT)
    ) ahb_master_top_i (
        .ahb_clk_in (clk), .ahb_rstn_in (rstn),
        .req_valid (req_valid), .req_addr (req_addr), .req_burst (req_burst),
        .req_size (req_size), .req_write (req_write), .wdata (wdata),
        .req_accept (req_accept), .wdata_take (wdata_take), .rsp_valid (rsp_valid),
        .rsp_rdata (rsp_rdata), .rsp_error (rsp_error), .haddr (haddr),
        .hburst (hburst), .hsize (hsize), .htrans (htrans), .hwrite (hwrite),
        .hwdata (hwdata), .hrdata (hrdata), .hready (hready), .hresp (hresp)
    );

    ahb_slave_model slave_i (
        .ahb_clk_in (clk), .ahb_rstn_in (rstn), .haddr (haddr), .htrans (htrans),
        .hwrite (hwrite), .hwdata (hwdata), .max_wait (max_wait), .stall (stall),
        .err_beat (err_beat), .hrdata (hrdata), .hready (hready), .hresp (hresp)
    );

    always #5 clk = ~clk;

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("Testbench failed");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] act);
        stop_run($sformatf("Mismatch at %0t: %s expected %h actual %h", $time, name, exp, act));
    endtask

    function automatic int beats_of(input logic [1:0] len);
        return (len == 2'd0) ? 1 : (2 << len);
    endfunction

    // The AHB rule increments by the size or wraps inside a window of beats times size.
    function automatic logic [31:0] expected_addr(input logic [31:0] start, input logic [1:0] len,
                                                  input logic incr, input logic [2:0] size,
                                                  input int i);
        int          sz;
        int          span;
        int          off;
        logic [31:0] base;
        sz   = 1 << size;
        span = beats_of(len) * sz;
        if (incr || len == 2'd0) begin
            return start + 32'(i * sz);
        end
        base = start - (start % 32'(span));
        off  = (int'(start - base) + i * sz) % span;
        return base + 32'(off);
    endfunction

    task automatic do_req(input logic [31:0] addr, input logic [2:0] burst,
                          input logic [2:0] size, input logic wr, input logic rej);
        int n;
        int k;
        int wi;
        n = rej ? 1 : beats_of(burst[2:1]);
        wq.delete();
        rd_q.delete();
        rsp_cnt = 0;
        got_err = 1'b0;
        exp_burst = burst;
        exp_size  = size;
        exp_write = wr;
        for (int i = 0; i < n; i++) begin
            wq.push_back($urandom());
            if (!rej) begin
                exp_q.push_back(expected_addr(addr, burst[2:1], burst[0], size, i));
                first_q.push_back(i == 0);
            end
        end
        rej_mode   = rej;
        req_addr  <= addr;
        req_burst <= burst;
        req_size  <= size;
        req_write <= wr;
        req_valid <= 1'b1;
        wdata     <= wq[0];
        wi = 0;
        do @(posedge clk); while (!req_accept);
        req_valid <= 1'b0;
        k = 0;
        forever begin
            @(posedge clk);
            k++;
            if (wdata_take) begin
                wi++;
                if (wi < n) begin
                    wdata <= wq[wi];
                end
            end
            if (rsp_valid) begin
                if (rej) begin
                    assert (k == 3 && rsp_error)
                        else stop_run("Rejected request gave no error two edges after accept");
                end
                if (wr || rsp_error) begin
                    assert (rsp_rdata == '0) else report_mismatch("rsp_rdata", '0, rsp_rdata);
                end
                rsp_cnt++;
                rd_q.push_back(rsp_rdata);
                if (rsp_error) begin
                    got_err = 1'b1;
                    exp_q.delete();
                    first_q.delete();
                    break;
                end
                if (rsp_cnt == n) begin
                    break;
                end
            end
        end
        rej_mode = 1'b0;
    endtask

    // All beats must have been issued by the time the last response arrives.
    task automatic expect_clean(input int n);
        assert (!got_err && rsp_cnt == n && exp_q.size() == 0)
            else stop_run("Burst returned an error or a response count unequal to its beats");
    endtask

    task automatic compare_reads(input int n);
        for (int i = 0; i < n; i++) begin
            assert (rd_q[i] == saved[i]) else report_mismatch("rsp_rdata", saved[i], rd_q[i]);
        end
    endtask

    // Each accepted beat must match the next address of the reference rule.
    always @(posedge clk) begin
        if (rstn && htrans != IDLE && hready) begin
            if (exp_q.size() == 0) begin
                stop_run("Bus beat issued while no beat was expected");
            end else begin
                assert (haddr == exp_q[0]) else report_mismatch("haddr", exp_q[0], haddr);
                assert (htrans == (first_q[0] ? NONSEQ : SEQ))
                    else report_mismatch("htrans", first_q[0] ? 32'd2 : 32'd3, 32'(htrans));
                assert (hburst == exp_burst) else report_mismatch("hburst", exp_burst, hburst);
                assert (hsize == exp_size) else report_mismatch("hsize", exp_size, hsize);
                assert (hwrite == exp_write) else report_mismatch("hwrite", exp_write, hwrite);
                void'(exp_q.pop_front());
                void'(first_q.pop_front());
            end
        end
    end

    assert property (@(posedge clk) disable iff (!rstn)
        (htrans != IDLE && !hready && !hresp && !stall) |=> ($stable(haddr) && $stable(htrans)))
        else stop_run("Address phase changed while hready was low");

    assert property (@(posedge clk) disable iff (!rstn) (!hready && !stall) |=> $stable(hwdata))
        else stop_run("hwdata changed while hready was low");

    assert property (@(posedge clk) disable iff (!rstn) rej_mode |-> htrans == IDLE)
        else stop_run("Bus activity seen for a rejected request");

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > LIMIT) begin
            stop_run("Timeout: the run exceeded its cycle limit");
        end
    end

    initial begin
        logic [1:0]  len;
        logic        incr;
        logic [2:0]  size;
        logic [31:0] addr;
        int          span;
        void'($urandom(32'hbe2ea064));
        clk = 1'b0;
        rstn = 1'b0;
        req_valid = 1'b0;
        req_addr = '0;
        req_burst = '0;
        req_size = '0;
        req_write = 1'b0;
        wdata = '0;
        max_wait = 0;
        stall = 1'b0;
        err_beat = -1;
        cycles = 0;
        rej_mode = 1'b0;
        exp_burst = '0;
        exp_size = '0;
        exp_write = 1'b0;
        repeat (4) @(posedge clk);
        rstn <= 1'b1;
        @(posedge clk);
        assert (htrans == IDLE && !rsp_valid) else stop_run("Bus not idle after reset");

        do_req(32'h100, 3'b000, 3'd2, 1'b1, 1'b0);
        expect_clean(1);
        saved = wq;
        do_req(32'h100, 3'b000, 3'd2, 1'b0, 1'b0);
        expect_clean(1);
        compare_reads(1);

        for (int t = 0; t < 16; t++) begin
            max_wait <= (t >= 8) ? 4 : 0;
            len  = 2'($urandom_range(3, 1));
            incr = 1'($urandom_range(1, 0));
            size = 3'($urandom_range(2, 0));
            span = beats_of(len) << size;
            addr = 32'($urandom_range(3, 0) * 1024) +
                   (32'($urandom_range(32'((1024 - span) >> size), 0)) << size);
            do_req(addr, {len, incr}, size, 1'b1, 1'b0);
            expect_clean(beats_of(len));
            saved = wq;
            do_req(addr, {len, incr}, size, 1'b0, 1'b0);
            expect_clean(beats_of(len));
            if (size == 3'd2) begin
                compare_reads(beats_of(len));
            end
        end
        max_wait <= 0;

        // Misaligned, too wide, and crossing 1 KB.
        do_req(32'h102, 3'b000, 3'd2, 1'b0, 1'b1);
        do_req(32'h200, 3'b000, 3'd3, 1'b0, 1'b1);
        do_req(32'h3f8, 3'b011, 3'd2, 1'b1, 1'b1);

        stall <= 1'b1;
        do_req(32'h40, 3'b011, 3'd2, 1'b0, 1'b0);
        assert (got_err && rsp_cnt == 1) else stop_run("Stalled slave gave no timeout error");
        stall <= 1'b0;
        repeat (4) @(posedge clk);
        do_req(32'h80, 3'b000, 3'd2, 1'b1, 1'b0);
        expect_clean(1);

        err_beat <= slave_i.beat_cnt + 2;
        do_req(32'h500, 3'b101, 3'd2, 1'b1, 1'b0);
        assert (got_err && rsp_cnt == 3) else stop_run("Slave error did not end the burst");
        err_beat <= -1;
        repeat (4) @(posedge clk);
        do_req(32'h600, 3'b011, 3'd2, 1'b1, 1'b0);
        expect_clean(4);

        $display("Testbench passed");
        $finish;
    end

endmodule
